/* design/mul_params.svh */
/*
 * iterative multiplier parameters
 * operand width and the width of the step counter
 */

`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------

// width of one two's-complement operand
`define MUL_OPND_W 32

// step counter width
// must hold MUL_OPND_W steps plus one
`define MUL_CNT_W 6

`endif

/* design/mul_pkg.sv */
/*
 * iterative multiplier package
 * vector types for operands, products and the step counter, plus FSM states
 */

package mul_pkg;

  `include "mul_params.svh"

  // --------------------------------------------------
  // datapath vectors
  // --------------------------------------------------

  // one signed operand, or its magnitude once converted
  typedef logic [`MUL_OPND_W-1:0] opnd_t;

  // partial or final product, double width
  typedef logic [2*`MUL_OPND_W-1:0] prod_t;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  // add-and-shift step counter
  typedef logic [`MUL_CNT_W-1:0] cnt_t;

  // control FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } mul_state_e;

endpackage

/* design/mul_iter_dpath.sv */
/*
 * iterative multiplier datapath
 * sign/magnitude split, add-and-shift accumulator and result sign fix-up
 */

`timescale 1ns/1ns

module mul_iter_dpath (
  input  logic            clk,
  input  logic            reset,

  // request operands, sampled on load
  input  mul_pkg::opnd_t  req_a,
  input  mul_pkg::opnd_t  req_b,

  // sequencing from the control unit
  input  logic            load,
  input  logic            step,

  // signed product
  output mul_pkg::prod_t  resp_result
);

  import mul_pkg::*;

  // operand width, taken from the type itself
  localparam int OPND_W = $bits(opnd_t);

  // --------------------------------------------------
  // magnitude helper
  // --------------------------------------------------

  // two's-complement absolute value
  // the most negative value maps to 2**(W-1), which still fits unsigned
  function automatic opnd_t magnitude(input opnd_t v);
    opnd_t neg_v;
    neg_v = ~v + opnd_t'(1);
    return v[OPND_W-1] ? neg_v : v;
  endfunction

  // --------------------------------------------------
  // operand conditioning
  // --------------------------------------------------

  opnd_t a_mag;
  opnd_t b_mag;
  logic  sign_in;

  assign a_mag = magnitude(req_a);
  assign b_mag = magnitude(req_b);

  // product is negative when exactly one operand is
  assign sign_in = req_a[OPND_W-1] ^ req_b[OPND_W-1];

  // --------------------------------------------------
  // working registers
  // --------------------------------------------------

  // multiplicand, moves left one place per step
  prod_t a_reg;
  // multiplier, moves right one place per step
  opnd_t b_reg;
  // running sum of the selected partial products
  prod_t acc_reg;
  // stored sign of the final product
  logic  neg_reg;

  // next values for one add-and-shift
  prod_t a_shift;
  opnd_t b_shift;
  prod_t acc_add;

  assign a_shift = a_reg << 1;
  assign b_shift = b_reg >> 1;

  // add the current multiplicand only when the low multiplier bit is set
  assign acc_add = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  // operand shift registers loaded on accept
  always_ff @(posedge clk) begin
    if (load) begin
      // zero-extend the magnitude into the wide shifter
      a_reg <= prod_t'(a_mag);
      b_reg <= b_mag;
    end else if (step) begin
      a_reg <= a_shift;
      b_reg <= b_shift;
    end
  end

  // accumulator and sign start from a known zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg <= '0;
      neg_reg <= 1'b0;
    end else if (load) begin
      // clear for the new operation
      acc_reg <= '0;
      neg_reg <= sign_in;
    end else if (step) begin
      acc_reg <= acc_add;
    end
  end

  // --------------------------------------------------
  // result
  // --------------------------------------------------

  prod_t acc_neg;

  // negated copy of the accumulated magnitude
  assign acc_neg = ~acc_reg + prod_t'(1);

  // straight from registers, no extra latency
  assign resp_result = neg_reg ? acc_neg : acc_reg;

endmodule

/* design/mul_iter_ctrl.sv */
/*
 * iterative multiplier control unit
 * idle/calc/done FSM with step counter, drives both valid/ready handshakes
 */

`timescale 1ns/1ns

`include "mul_params.svh"

module mul_iter_ctrl (
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath sequencing
  output logic load,
  output logic step
);

  import mul_pkg::*;

  // counter value during the final add-and-shift
  localparam cnt_t LAST_STEP = cnt_t'(`MUL_OPND_W - 1);

  // --------------------------------------------------
  // state and counter
  // --------------------------------------------------

  mul_state_e state;
  mul_state_e state_next;
  cnt_t       cnt;
  cnt_t       cnt_next;

  // transfers on either port
  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      cnt   <= cnt_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_next = state;
    cnt_next   = cnt;

    unique case (state)
      ST_IDLE: begin
        // wait for a request, restart the step count
        if (req_go) begin
          state_next = ST_CALC;
          cnt_next   = '0;
        end
      end

      ST_CALC: begin
        // one step per cycle
        cnt_next = cnt + cnt_t'(1);
        if (cnt == LAST_STEP) begin
          state_next = ST_DONE;
        end
      end

      ST_DONE: begin
        // hold the result until the consumer takes it
        if (resp_go) begin
          state_next = ST_IDLE;
        end
      end

      default: begin
        state_next = ST_IDLE;
        cnt_next   = '0;
      end
    endcase
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  // handshake outputs decode the state only
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    load     = 1'b0;
    step     = 1'b0;

    unique case (state)
      ST_IDLE: begin
        req_rdy = 1'b1;
        // req_rdy is high here, so this is the request transfer
        load    = req_val;
      end

      ST_CALC: begin
        step = 1'b1;
      end

      ST_DONE: begin
        resp_val = 1'b1;
      end

      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

/* design/mul_iter.sv */
/*
 * iterative signed multiplier, top level
 * control unit and datapath behind valid/ready request and response ports
 */

`timescale 1ns/1ns

module mul_iter (
  input  logic            clk,
  input  logic            reset,

  // request port
  input  mul_pkg::opnd_t  req_a,
  input  mul_pkg::opnd_t  req_b,
  input  logic            req_val,
  output logic            req_rdy,

  // response port
  output mul_pkg::prod_t  resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  // --------------------------------------------------
  // control to datapath
  // --------------------------------------------------

  // capture operands and clear the accumulator
  logic load;
  // one add-and-shift
  logic step;

  // --------------------------------------------------
  // control unit
  // --------------------------------------------------

  // sequences the 32 steps and owns both handshakes
  mul_iter_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // operands go straight in, sampled only on load
  mul_iter_dpath dpath0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .resp_result (resp_result)
  );

endmodule

/* tb/mul_iter_props.sv */
/*
 * handshake and timing assertions for the iterative multiplier
 * bound to the top level, sees its ports only
 */

`timescale 1ns/1ns

module mul_iter_props (
  input logic            clk,
  input logic            reset,
  input mul_pkg::opnd_t  req_a,
  input mul_pkg::opnd_t  req_b,
  input logic            req_val,
  input logic            req_rdy,
  input mul_pkg::prod_t  resp_result,
  input logic            resp_val,
  input logic            resp_rdy
);

  import mul_pkg::*;

  // one add-and-shift per operand bit
  localparam int STEPS = $bits(opnd_t);

  // number of failed assertions, read by the testbench
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  logic req_go;
  logic resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------

  // a waiting request keeps its operands
  req_hold_a: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req_a) && $stable(req_b))
    else begin $error("request dropped or changed before transfer"); fail_cnt++; end

  // busy from the cycle after accept until the response is taken
  busy_a: assert property (@(posedge clk) disable iff (reset)
    req_go |=> !req_rdy)
    else begin $error("req_rdy high right after an accept"); fail_cnt++; end

  busy_hold_a: assert property (@(posedge clk) disable iff (reset)
    !req_rdy && !resp_go |=> !req_rdy)
    else begin $error("req_rdy rose before the response transfer"); fail_cnt++; end

  // back to idle one cycle after the response transfer
  idle_again_a: assert property (@(posedge clk) disable iff (reset)
    resp_go |=> req_rdy)
    else begin $error("req_rdy low after the response transfer"); fail_cnt++; end

  one_op_a: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else begin $error("req_rdy and resp_val high together"); fail_cnt++; end

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  // 32 busy cycles, result on the 33rd
  latency_a: assert property (@(posedge clk) disable iff (reset)
    req_go |=> (!resp_val) [*STEPS] ##1 resp_val)
    else begin $error("response latency is not the fixed step count"); fail_cnt++; end

  // stalled response holds valid and data
  stall_hold_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin $error("response changed while stalled"); fail_cnt++; end

  // reset leaves the unit idle
  reset_state_a: assert property (@(posedge clk)
    reset |=> req_rdy && !resp_val)
    else begin $error("unit not idle after reset"); fail_cnt++; end

endmodule

/* tb/mul_iter_tb.sv */
/*
 * testbench for the iterative signed multiplier
 * directed and xorshift operands, response back-pressure and scoreboard
 */

`timescale 1ns/1ns

`include "mul_params.svh"

module mul_iter_tb;

  import mul_pkg::*;

  localparam int W = `MUL_OPND_W;

  // --------------------------------------------------
  // run length
  // --------------------------------------------------

  localparam int N_DIR = 13;
  localparam int N_RAND = 200;
  localparam int N_BP = 40;
  // one aborted by reset, two after it
  localparam int N_RST = 3;
  localparam int N_OPS = N_DIR + N_RAND + N_BP + N_RST;
  // stall stretches per back-pressured op, plus the reset pulse
  localparam int STALL_BUDGET = N_BP * 64 + 20;
  localparam int CYCLE_LIMIT = (N_OPS * 34 + STALL_BUDGET) * 2;

  localparam logic [31:0] SEED = 32'h8627_0f69;

  localparam opnd_t OPND_MAX = {1'b0, {(W-1){1'b1}}};
  localparam opnd_t OPND_MIN = {1'b1, {(W-1){1'b0}}};

  logic  clk;
  logic  reset;
  opnd_t req_a;
  opnd_t req_b;
  logic  req_val;
  logic  req_rdy;
  prod_t resp_result;
  logic  resp_val;
  logic  resp_rdy;

  // expected products with the name of the test that sent them
  prod_t exp_q[$];
  string name_q[$];

  int          err_cnt;
  int          cycles;
  logic [31:0] op_state;
  logic [31:0] bp_state;
  logic        bp_mode;
  int          stall_left;

  mul_iter dut0 (.*);

  bind mul_iter mul_iter_props props0 (.*);

  always #20 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // full signed product at double width
  function automatic prod_t signed_product(input opnd_t a, input opnd_t b);
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    sa = $signed(a);
    sb = $signed(b);
    return prod_t'(sa * sb);
  endfunction

  // present one request, hold it until accepted
  task automatic send(input opnd_t a, input opnd_t b, input string name);
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    // at the falling edge a high req_rdy means a transfer on the next rise
    do @(negedge clk); while (!(req_rdy && !reset));
    exp_q.push_back(signed_product(a, b));
    name_q.push_back(name);
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic drain();
    do @(posedge clk); while (exp_q.size() != 0);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic finish_run(input bit timed_out);
    if (timed_out) begin
      $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
      err_cnt++;
    end
    $display("errors: %0d, assertion failures: %0d", err_cnt, dut0.props0.fail_cnt);
    if (err_cnt == 0 && dut0.props0.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // response side
  // --------------------------------------------------

  // always ready, or random low stretches in the back-pressure phase
  always @(posedge clk) begin : consumer
    logic stall_mode;
    // phase as it stood before this edge
    stall_mode = bp_mode;
    #1;
    if (!stall_mode) begin
      resp_rdy = 1'b1;
    end else if (stall_left != 0) begin
      resp_rdy = 1'b0;
      stall_left--;
    end else begin
      bp_state = xorshift(bp_state);
      if (bp_state[1:0] == 2'b00) begin
        stall_left = bp_state[7:4];
        resp_rdy = 1'b0;
      end else begin
        resp_rdy = 1'b1;
      end
    end
  end

  // compare each response transfer with the oldest request
  always @(negedge clk) begin : scoreboard
    prod_t exp_v;
    string nm;
    if (reset) begin
      exp_q.delete();
      name_q.delete();
    end else if (resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response transfer with no request outstanding");
        err_cnt++;
      end else begin
        exp_v = exp_q.pop_front();
        nm = name_q.pop_front();
        result_check: assert (resp_result === exp_v) else begin
          $display("Error: %s expected %h actual %h", nm, exp_v, resp_result);
          err_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      finish_run(1'b1);
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b1;
    bp_mode    = 1'b0;
    stall_left = 0;
    err_cnt    = 0;
    cycles     = 0;
    op_state   = SEED;
    bp_state   = SEED;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // corner operands
    send(opnd_t'(0), opnd_t'(0), "zero_zero");
    send(opnd_t'(0), opnd_t'(-5), "zero_neg");
    send(opnd_t'(1), opnd_t'(1), "one_one");
    send(opnd_t'(1), opnd_t'(-1), "one_neg_one");
    send(opnd_t'(-1), opnd_t'(-1), "neg_one_sq");
    send(opnd_t'(7), opnd_t'(-3), "pos_neg");
    send(opnd_t'(-12345), opnd_t'(678), "neg_pos");
    send(opnd_t'(-100), opnd_t'(-200), "neg_neg");
    send(OPND_MAX, OPND_MAX, "max_sq");
    send(OPND_MAX, opnd_t'(-1), "max_neg_one");
    send(OPND_MIN, OPND_MIN, "min_sq");
    send(OPND_MIN, opnd_t'(1), "min_one");
    send(OPND_MIN, OPND_MAX, "min_max");
    drain();

    // random operands, consumer always ready
    for (int i = 0; i < N_RAND; i++) begin
      op_state = xorshift(op_state);
      req_a = opnd_t'(op_state);
      op_state = xorshift(op_state);
      send(req_a, opnd_t'(op_state), "random");
    end
    drain();

    // random operands with a stalling consumer
    bp_mode = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      op_state = xorshift(op_state);
      req_a = opnd_t'(op_state);
      op_state = xorshift(op_state);
      send(req_a, opnd_t'(op_state), "backpressure");
    end
    drain();
    bp_mode = 1'b0;

    // reset in the middle of an operation
    send(opnd_t'(5), opnd_t'(6), "reset_abort");
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    send(opnd_t'(-9), opnd_t'(11), "after_reset");
    send(OPND_MIN, opnd_t'(-1), "after_reset");
    drain();

    finish_run(1'b0);
  end

endmodule

/* src.f */
+incdir+design
design/mul_pkg.sv
design/mul_iter_dpath.sv
design/mul_iter_ctrl.sv
design/mul_iter.sv
tb/mul_iter_props.sv
tb/mul_iter_tb.sv
